//--- Bender.yml
package:
  name: dispatch

export_include_dirs:
  - hdl

sources:
  - hdl/dispatch_pkg.sv
  - hdl/control_unit.sv
  - hdl/reg_status_table.sv
  - hdl/dispatch.sv
  - hdl/fu_status_table.sv
  - hdl/dispatch_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/dispatch_assert.sv
      - testbench/dispatch_tb.sv

//--- hdl/control_unit.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module control_unit (
    input  logic [`WORD_W-1:0]    instr,
    output dispatch_pkg::decode_t dec
);

    import dispatch_pkg::*;

    opcode_t opcode;

    assign opcode = opcode_t'(instr[6:0]);

    always_comb begin
        // unknown opcodes fall through as a no-op with every write off
        dec        = '0;
        dec.alu_op = instr[14:12];
        dec.imm    = instr[31:20];

        case (opcode)
            OP_ALU, OP_ALUI: begin
                dec.fu_t        = FU_S_T;
                dec.fu_s        = FU_S_ALU;
                dec.s_reg_write = 1'b1;
            end
            OP_LOAD: begin
                dec.fu_t        = FU_S_T;
                dec.fu_s        = FU_S_LD_ST;
                dec.s_reg_write = 1'b1;
                dec.s_mem_type  = M_LOAD;
            end
            OP_STORE: begin
                dec.fu_t       = FU_S_T;
                dec.fu_s       = FU_S_LD_ST;
                dec.s_mem_type = M_STORE;
            end
            OP_BRANCH: begin
                dec.fu_t = FU_S_T;
                dec.fu_s = FU_S_BRANCH;
            end
            OP_MLOAD: begin
                dec.fu_t       = FU_M_T;
                dec.fu_m       = FU_M_LD_ST;
                dec.m_mem_type = M_LOAD;
            end
            OP_MSTORE: begin
                dec.fu_t       = FU_M_T;
                dec.fu_m       = FU_M_LD_ST;
                dec.m_mem_type = M_STORE;
            end
            OP_GEMM: begin
                dec.fu_t = FU_G_T;
                dec.fu_m = FU_M_GEMM;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/dispatch.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module dispatch (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic [`WORD_W-1:0]          instr,
    input  logic                        instr_valid,
    input  dispatch_pkg::wb_t           wb,
    input  logic [`NUM_FU-1:0]          busy_in,
    input  logic                        branch_resolved,
    input  logic                        branch_miss,
    output logic                        freeze,
    output logic [`NUM_FU-1:0]          row_write,
    output dispatch_pkg::fust_row_t     new_row,
    output dispatch_pkg::dispatch_t     dispatch_out
);

    import dispatch_pkg::*;

    decode_t                dec;
    s_reg_t                 s_rd, s_rs1, s_rs2;
    m_reg_t                 m_rd, m_rs1, m_rs2;
    rst_entry_t [`S_REGS-1:0] s_status;
    rst_entry_t [`M_REGS-1:0] m_status;
    logic                   s_di_write, m_di_write;
    logic [`TAG_W-1:0]      s_di_tag, m_di_tag;
    logic                   m_reg_write;
    logic                   struct_hazard, waw_hazard;
    logic                   accept;
    logic                   spec, n_spec;
    dispatch_t              decoded, n_dispatch;

    // an idle register reports ready regardless of its stored tag
    function automatic logic [`TAG_W-1:0] tag_of(input rst_entry_t e);
        return e.busy ? e.tag : '0;
    endfunction

    control_unit u_cu (
        .instr (instr),
        .dec   (dec)
    );

    assign s_rd  = instr[11:7];
    assign s_rs1 = instr[19:15];
    assign s_rs2 = instr[24:20];
    assign m_rd  = instr[31:28];
    assign m_rs1 = instr[27:24];
    assign m_rs2 = instr[23:20];

    always_comb begin
        case (dec.fu_t)
            FU_S_T:  struct_hazard = busy_in[dec.fu_s];
            FU_M_T:  struct_hazard = busy_in[`ROW_M_LD_ST];
            FU_G_T:  struct_hazard = busy_in[`ROW_GEMM];
            default: struct_hazard = 1'b0;
        endcase

        m_reg_write = (dec.m_mem_type == M_LOAD) || (dec.fu_m == FU_M_GEMM);
        if (m_reg_write) begin
            waw_hazard = m_status[m_rd].busy;
        end else if (dec.s_reg_write) begin
            waw_hazard = s_status[s_rd].busy;
        end else begin
            waw_hazard = 1'b0;
        end
    end

    assign freeze = instr_valid && (struct_hazard || waw_hazard);
    assign accept = instr_valid && !freeze && !branch_miss;

    // producer tags, loads resolve through tag 2
    assign s_di_write = accept && dec.s_reg_write;
    assign s_di_tag   = (dec.fu_s == FU_S_LD_ST) ? `TAG_LDST : `TAG_ARITH;
    assign m_di_write = accept && m_reg_write;
    assign m_di_tag   = (dec.fu_m == FU_M_LD_ST) ? `TAG_LDST : `TAG_ARITH;

    reg_status_table #(.NREGS(`S_REGS)) u_rst_s (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (s_di_write),
        .di_sel   (s_rd),
        .di_tag   (s_di_tag),
        .di_spec  (spec),
        .wb_write (wb.s_rw_en),
        .wb_sel   (wb.s_rw),
        .flush    (branch_miss),
        .status   (s_status)
    );

    // matrix producers are never marked speculative
    reg_status_table #(.NREGS(`M_REGS)) u_rst_m (
        .CLK      (CLK),
        .nRST     (nRST),
        .di_write (m_di_write),
        .di_sel   (m_rd),
        .di_tag   (m_di_tag),
        .di_spec  (1'b0),
        .wb_write (wb.m_rw_en),
        .wb_sel   (wb.m_rw),
        .flush    (branch_miss),
        .status   (m_status)
    );

    always_comb begin
        n_spec = spec;
        if (branch_resolved || branch_miss) begin
            n_spec = 1'b0;
        end else if (accept && dec.fu_t == FU_S_T && dec.fu_s == FU_S_BRANCH) begin
            n_spec = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            spec <= 1'b0;
        end else begin
            spec <= n_spec;
        end
    end

    // row for the issue stage, operand tags come from the registered tables
    always_comb begin
        new_row      = '0;
        new_row.busy = 1'b1;
        new_row.spec = spec;
        row_write    = '0;
        case (dec.fu_t)
            FU_S_T: begin
                new_row.rd  = s_rd;
                new_row.rs1 = s_rs1;
                new_row.rs2 = s_rs2;
                new_row.t1  = tag_of(s_status[s_rs1]);
                new_row.t2  = tag_of(s_status[s_rs2]);
                row_write[dec.fu_s] = accept;
            end
            FU_M_T: begin
                // addresses come from scalar registers
                new_row.rd  = s_reg_t'(m_rd);
                new_row.rs1 = s_reg_t'(m_rs1);
                new_row.rs2 = s_reg_t'(m_rs2);
                new_row.t1  = tag_of(s_status[s_rs1]);
                new_row.t2  = tag_of(s_status[s_rs2]);
                row_write[`ROW_M_LD_ST] = accept;
            end
            FU_G_T: begin
                new_row.rd  = s_reg_t'(m_rd);
                new_row.rs1 = s_reg_t'(m_rs1);
                new_row.rs2 = s_reg_t'(m_rs2);
                new_row.t1  = tag_of(m_status[m_rs1]);
                new_row.t2  = tag_of(m_status[m_rs2]);
                row_write[`ROW_GEMM] = accept;
            end
            default: ;
        endcase
    end

    always_comb begin
        decoded            = '0;
        decoded.fu_s       = dec.fu_s;
        decoded.fu_m       = dec.fu_m;
        decoded.imm        = dec.imm;
        decoded.alu_op     = dec.alu_op;
        decoded.s_mem_type = dec.s_mem_type;
        decoded.m_mem_type = dec.m_mem_type;
        decoded.s_rw_en    = dec.s_reg_write;
        decoded.s_rw       = s_rd;

        // squash wins over hold
        if (branch_miss || !instr_valid) begin
            n_dispatch = '0;
        end else if (freeze) begin
            n_dispatch = dispatch_out;
        end else begin
            n_dispatch = decoded;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            dispatch_out <= '0;
        end else begin
            dispatch_out <= n_dispatch;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dispatch_config.svh
`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

`default_nettype none

// instruction word and register file sizes
`define WORD_W 32
`define S_REGS 32
`define M_REGS 16

// producer tags, 0 means the value is ready
`define TAG_W     2
`define TAG_ARITH 2'd1
`define TAG_LDST  2'd2

// functional unit rows, scalar rows follow fu_s_t
`define NUM_FU      5
`define ROW_M_LD_ST 3
`define ROW_GEMM    4

`default_nettype wire

`endif

//--- hdl/dispatch_pkg.sv
`include "dispatch_config.svh"

`default_nettype none

package dispatch_pkg;

    typedef logic [$clog2(`S_REGS)-1:0] s_reg_t;
    typedef logic [$clog2(`M_REGS)-1:0] m_reg_t;

    // major opcodes in bits 6:0
    typedef enum logic [6:0] {
        OP_ALU    = 7'b0110011,
        OP_ALUI   = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_MLOAD  = 7'b0000111,
        OP_MSTORE = 7'b0100111,
        OP_GEMM   = 7'b1110111
    } opcode_t;

    typedef enum logic [1:0] {FU_NONE, FU_S_T, FU_M_T, FU_G_T} fu_type_t;

    // also the row index of each scalar unit
    typedef enum logic [1:0] {FU_S_ALU, FU_S_LD_ST, FU_S_BRANCH} fu_s_t;

    typedef enum logic [1:0] {FU_M_NONE, FU_M_LD_ST, FU_M_GEMM} fu_m_t;

    typedef enum logic [1:0] {M_NONE, M_LOAD, M_STORE} mem_type_t;

    typedef struct packed {
        fu_type_t   fu_t;
        fu_s_t      fu_s;
        fu_m_t      fu_m;
        logic       s_reg_write;
        mem_type_t  s_mem_type;
        mem_type_t  m_mem_type;
        logic [2:0] alu_op;
        logic [11:0] imm;
    } decode_t;

    typedef struct packed {
        logic             busy;
        logic             spec;
        logic [`TAG_W-1:0] tag;
    } rst_entry_t;

    // pipeline register toward execute and writeback
    typedef struct packed {
        fu_s_t       fu_s;
        fu_m_t       fu_m;
        logic [11:0] imm;
        logic [2:0]  alu_op;
        mem_type_t   s_mem_type;
        mem_type_t   m_mem_type;
        logic        s_rw_en;
        s_reg_t      s_rw;
    } dispatch_t;

    typedef struct packed {
        logic             busy;
        logic             spec;
        s_reg_t           rd;
        s_reg_t           rs1;
        s_reg_t           rs2;
        logic [`TAG_W-1:0] t1;
        logic [`TAG_W-1:0] t2;
    } fust_row_t;

    // commit broadcast from writeback
    typedef struct packed {
        logic   s_rw_en;
        s_reg_t s_rw;
        logic   m_rw_en;
        m_reg_t m_rw;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/dispatch_top.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module dispatch_top (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic [`WORD_W-1:0]                    instr,
    input  logic                                  instr_valid,
    input  dispatch_pkg::wb_t                     wb,
    input  logic [`NUM_FU-1:0]                    fu_done,
    input  logic                                  branch_resolved,
    input  logic                                  branch_miss,
    output logic                                  freeze,
    output dispatch_pkg::dispatch_t               dispatch_out,
    output dispatch_pkg::fust_row_t [`NUM_FU-1:0] fust_rows,
    output logic [`NUM_FU-1:0]                    issue_ready
);

    import dispatch_pkg::*;

    logic [`NUM_FU-1:0] row_write;
    logic [`NUM_FU-1:0] fu_busy;
    fust_row_t          new_row;

    dispatch u_dispatch (
        .CLK             (CLK),
        .nRST            (nRST),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .wb              (wb),
        .busy_in         (fu_busy),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .freeze          (freeze),
        .row_write       (row_write),
        .new_row         (new_row),
        .dispatch_out    (dispatch_out)
    );

    // busy feeds back for the structural hazard check
    fu_status_table u_fust (
        .CLK         (CLK),
        .nRST        (nRST),
        .row_write   (row_write),
        .new_row     (new_row),
        .fu_done     (fu_done),
        .rows        (fust_rows),
        .busy        (fu_busy),
        .issue_ready (issue_ready)
    );

endmodule

`default_nettype wire

//--- hdl/fu_status_table.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module fu_status_table (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  logic [`NUM_FU-1:0]                    row_write,
    input  dispatch_pkg::fust_row_t               new_row,
    input  logic [`NUM_FU-1:0]                    fu_done,
    output dispatch_pkg::fust_row_t [`NUM_FU-1:0] rows,
    output logic [`NUM_FU-1:0]                    busy,
    output logic [`NUM_FU-1:0]                    issue_ready
);

    import dispatch_pkg::*;

    fust_row_t [`NUM_FU-1:0] n_rows;

    function automatic logic [`TAG_W-1:0] clear_tag(
        input logic [`TAG_W-1:0] tag,
        input logic              clr_arith,
        input logic              clr_ldst
    );
        if ((tag == `TAG_ARITH && clr_arith) || (tag == `TAG_LDST && clr_ldst)) begin
            return '0;
        end
        return tag;
    endfunction

    always_comb begin
        logic clr_arith;
        logic clr_ldst;
        n_rows = rows;
        for (int r = 0; r < `NUM_FU; r++) begin
            // scalar rows listen to scalar units, matrix rows to matrix units
            if (r < `ROW_M_LD_ST) begin
                clr_arith = fu_done[FU_S_ALU];
                clr_ldst  = fu_done[FU_S_LD_ST];
            end else begin
                clr_arith = fu_done[`ROW_GEMM];
                clr_ldst  = fu_done[`ROW_M_LD_ST];
            end
            n_rows[r].t1 = clear_tag(rows[r].t1, clr_arith, clr_ldst);
            n_rows[r].t2 = clear_tag(rows[r].t2, clr_arith, clr_ldst);
            if (fu_done[r]) begin
                n_rows[r] = '0;
            end
            // new row still sees results broadcast this cycle
            if (row_write[r]) begin
                n_rows[r]    = new_row;
                n_rows[r].t1 = clear_tag(new_row.t1, clr_arith, clr_ldst);
                n_rows[r].t2 = clear_tag(new_row.t2, clr_arith, clr_ldst);
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= n_rows;
        end
    end

    always_comb begin
        for (int r = 0; r < `NUM_FU; r++) begin
            busy[r]        = rows[r].busy;
            issue_ready[r] = rows[r].busy && rows[r].t1 == '0 && rows[r].t2 == '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/reg_status_table.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module reg_status_table #(
    parameter int NREGS = `S_REGS
) (
    input  logic                             CLK,
    input  logic                             nRST,
    input  logic                             di_write,
    input  logic [$clog2(NREGS)-1:0]         di_sel,
    input  logic [`TAG_W-1:0]                di_tag,
    input  logic                             di_spec,
    input  logic                             wb_write,
    input  logic [$clog2(NREGS)-1:0]         wb_sel,
    input  logic                             flush,
    output dispatch_pkg::rst_entry_t [NREGS-1:0] status
);

    import dispatch_pkg::*;

    rst_entry_t [NREGS-1:0] n_status;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            status <= '0;
        end else begin
            status <= n_status;
        end
    end

    // later assignments take priority: flush, then writeback, then dispatch
    always_comb begin
        n_status = status;
        for (int i = 0; i < NREGS; i++) begin
            // mispredicted path drops its producers
            if (flush && status[i].spec) begin
                n_status[i] = '0;
            end
            if (wb_write && wb_sel == i) begin
                n_status[i] = '0;
            end
            // a new producer overrides a commit to the same register
            if (di_write && di_sel == i) begin
                n_status[i].busy = 1'b1;
                n_status[i].spec = di_spec;
                n_status[i].tag  = di_tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/dispatch_pkg.sv
hdl/control_unit.sv
hdl/reg_status_table.sv
hdl/dispatch.sv
hdl/fu_status_table.sv
hdl/dispatch_top.sv
testbench/tb_clock_gen.sv
testbench/dispatch_assert.sv
testbench/dispatch_tb.sv

//--- testbench/dispatch_assert.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module dispatch_assert (
    input logic                    CLK,
    input logic                    nRST,
    input logic                    freeze,
    input logic                    branch_miss,
    input logic [`NUM_FU-1:0]      row_write,
    input dispatch_pkg::dispatch_t dispatch_out,
    input logic [`NUM_FU-1:0]      issue_ready
);

    // failed property count read by the testbench
    int failures = 0;

    // a stalled instruction must leave the status rows untouched
    no_write_on_freeze: assert property (
        @(posedge CLK) disable iff (!nRST) freeze |-> row_write == '0
    ) else begin
        $error("row written while freeze is high");
        failures++;
    end

    // the instruction in dispatch is dropped on a miss
    no_write_on_miss: assert property (
        @(posedge CLK) disable iff (!nRST) branch_miss |-> row_write == '0
    ) else begin
        $error("row written during branch_miss");
        failures++;
    end

    outputs_clear_after_reset: assert property (
        @(posedge CLK) $rose(nRST) |-> (dispatch_out == '0 && issue_ready == '0)
    ) else begin
        $error("dispatch_out or issue_ready not zero after reset");
        failures++;
    end

endmodule

`default_nettype wire

//--- testbench/dispatch_tb.sv
`timescale 1ns/1ps
`include "dispatch_config.svh"

`default_nettype none

module dispatch_tb;

    import dispatch_pkg::*;

    localparam int PERIOD_NS    = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CYCLES   = 2000;
    localparam int WATCHDOG_NS  = (NUM_CYCLES + 100) * PERIOD_NS;

    logic                    CLK;
    logic                    nRST;
    logic [`WORD_W-1:0]      instr;
    logic                    instr_valid;
    wb_t                     wb;
    logic [`NUM_FU-1:0]      fu_done;
    logic                    branch_resolved;
    logic                    branch_miss;
    logic                    freeze;
    dispatch_t               dispatch_out;
    fust_row_t [`NUM_FU-1:0] fust_rows;
    logic [`NUM_FU-1:0]      issue_ready;

    // reference model state
    rst_entry_t model_s [`S_REGS];
    rst_entry_t model_m [`M_REGS];
    fust_row_t  model_rows [`NUM_FU];
    dispatch_t  model_disp;
    logic       model_spec;
    logic       last_freeze;

    logic [15:0] lfsr_state = 16'd73;
    int          errors = 0;
    int          accepted = 0;
    int          stalls = 0;

    // last entry is outside the opcode enum and decodes as a no-op
    logic [6:0] opcode_list [0:8] = '{OP_ALU, OP_ALUI, OP_LOAD, OP_STORE, OP_BRANCH,
                                      OP_MLOAD, OP_MSTORE, OP_GEMM, 7'h7f};

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clk (
        .CLK  (CLK),
        .nRST (nRST)
    );

    dispatch_top uut (
        .CLK             (CLK),
        .nRST            (nRST),
        .instr           (instr),
        .instr_valid     (instr_valid),
        .wb              (wb),
        .fu_done         (fu_done),
        .branch_resolved (branch_resolved),
        .branch_miss     (branch_miss),
        .freeze          (freeze),
        .dispatch_out    (dispatch_out),
        .fust_rows       (fust_rows),
        .issue_ready     (issue_ready)
    );

    bind dispatch_top dispatch_assert u_assert (
        .CLK          (CLK),
        .nRST         (nRST),
        .freeze       (freeze),
        .branch_miss  (branch_miss),
        .row_write    (row_write),
        .dispatch_out (dispatch_out),
        .issue_ready  (issue_ready)
    );

    // 16-bit Galois LFSR stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [`TAG_W-1:0] ready_tag(input rst_entry_t e);
        return e.busy ? e.tag : '0;
    endfunction

    function automatic logic [`TAG_W-1:0] drop_tag(input logic [`TAG_W-1:0] t,
                                                   input logic arith, input logic ldst);
        if ((t == `TAG_ARITH && arith) || (t == `TAG_LDST && ldst)) begin
            return '0;
        end
        return t;
    endfunction

    // row -1 means no target unit
    function automatic void decode_model(input logic [`WORD_W-1:0] ins, output int row,
                                         output logic s_wr, output logic m_wr,
                                         output logic [`TAG_W-1:0] tag, output dispatch_t d);
        d        = '0;
        row      = -1;
        s_wr     = 1'b0;
        m_wr     = 1'b0;
        tag      = `TAG_ARITH;
        d.imm    = ins[31:20];
        d.alu_op = ins[14:12];
        d.s_rw   = ins[11:7];
        case (ins[6:0])
            OP_ALU, OP_ALUI: begin
                row  = 0;
                s_wr = 1'b1;
            end
            OP_LOAD, OP_STORE: begin
                row    = 1;
                d.fu_s = FU_S_LD_ST;
                tag    = `TAG_LDST;
                s_wr   = (ins[6:0] == OP_LOAD);
                d.s_mem_type = s_wr ? M_LOAD : M_STORE;
            end
            OP_BRANCH: begin
                row    = 2;
                d.fu_s = FU_S_BRANCH;
            end
            OP_MLOAD, OP_MSTORE: begin
                row    = 3;
                d.fu_m = FU_M_LD_ST;
                tag    = `TAG_LDST;
                m_wr   = (ins[6:0] == OP_MLOAD);
                d.m_mem_type = m_wr ? M_LOAD : M_STORE;
            end
            OP_GEMM: begin
                row    = 4;
                d.fu_m = FU_M_GEMM;
                m_wr   = 1'b1;
            end
            default: ;
        endcase
        d.s_rw_en = s_wr;
    endfunction

    function automatic logic model_freeze();
        int                row;
        logic              s_wr;
        logic              m_wr;
        logic [`TAG_W-1:0] tag;
        dispatch_t         d;
        logic              hazard;
        decode_model(instr, row, s_wr, m_wr, tag, d);
        hazard = 1'b0;
        if (row >= 0) begin
            hazard = model_rows[row].busy;
        end
        if (m_wr) begin
            hazard = hazard || model_m[instr[31:28]].busy;
        end else if (s_wr) begin
            hazard = hazard || model_s[instr[11:7]].busy;
        end
        return instr_valid && hazard;
    endfunction

    task automatic step_model();
        int                row;
        logic              s_wr;
        logic              m_wr;
        logic [`TAG_W-1:0] tag;
        dispatch_t         d;
        logic              frz;
        logic              acc;
        logic              arith;
        logic              ldst;
        fust_row_t         nr;
        decode_model(instr, row, s_wr, m_wr, tag, d);
        frz = model_freeze();
        acc = instr_valid && !frz && !branch_miss;
        last_freeze = frz;
        accepted += acc;
        stalls += frz;

        // new row sees the tables before this cycle's updates
        nr      = '0;
        nr.busy = 1'b1;
        nr.spec = model_spec;
        if (row >= 3) begin
            nr.rd  = instr[31:28];
            nr.rs1 = instr[27:24];
            nr.rs2 = instr[23:20];
        end else begin
            nr.rd  = instr[11:7];
            nr.rs1 = instr[19:15];
            nr.rs2 = instr[24:20];
        end
        if (row == 4) begin
            nr.t1 = ready_tag(model_m[instr[27:24]]);
            nr.t2 = ready_tag(model_m[instr[23:20]]);
        end else begin
            nr.t1 = ready_tag(model_s[instr[19:15]]);
            nr.t2 = ready_tag(model_s[instr[24:20]]);
        end

        for (int r = 0; r < `NUM_FU; r++) begin
            arith = (r < 3) ? fu_done[0] : fu_done[4];
            ldst  = (r < 3) ? fu_done[1] : fu_done[3];
            model_rows[r].t1 = drop_tag(model_rows[r].t1, arith, ldst);
            model_rows[r].t2 = drop_tag(model_rows[r].t2, arith, ldst);
            if (fu_done[r]) begin
                model_rows[r] = '0;
            end
            if (acc && row == r) begin
                model_rows[r]    = nr;
                model_rows[r].t1 = drop_tag(nr.t1, arith, ldst);
                model_rows[r].t2 = drop_tag(nr.t2, arith, ldst);
            end
        end

        for (int i = 0; i < `S_REGS; i++) begin
            if ((branch_miss && model_s[i].spec) || (wb.s_rw_en && wb.s_rw == i)) begin
                model_s[i] = '0;
            end
            if (acc && s_wr && instr[11:7] == i) begin
                model_s[i] = '{busy: 1'b1, spec: model_spec, tag: tag};
            end
        end
        for (int i = 0; i < `M_REGS; i++) begin
            if ((branch_miss && model_m[i].spec) || (wb.m_rw_en && wb.m_rw == i)) begin
                model_m[i] = '0;
            end
            if (acc && m_wr && instr[31:28] == i) begin
                model_m[i] = '{busy: 1'b1, spec: 1'b0, tag: tag};
            end
        end

        if (branch_miss || !instr_valid) begin
            model_disp = '0;
        end else if (!frz) begin
            model_disp = d;
        end

        if (branch_resolved || branch_miss) begin
            model_spec = 1'b0;
        end else if (acc && row == 2) begin
            model_spec = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        logic [`WORD_W-1:0] ins;
        wb_t                w;
        // fetch holds the word while dispatch is stalled
        if (!last_freeze) begin
            ins[6:0]    = opcode_list[take_bits(4) % 9];
            ins[31:7]   = 25'(take_bits(25));
            instr       <= ins;
            instr_valid <= (take_bits(2) != 0);
        end
        fu_done   <= 5'(take_bits(5)) & 5'(take_bits(5));
        w.s_rw_en = (take_bits(1) != 0);
        w.s_rw    = 5'(take_bits(5));
        w.m_rw_en = (take_bits(1) != 0);
        w.m_rw    = 4'(take_bits(4));
        wb        <= w;
        branch_miss     <= (take_bits(5) == 0);
        branch_resolved <= (take_bits(4) == 0);
    endtask

    task automatic stop_on_error();
        errors++;
        $display("Test failed");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_freeze(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: freeze got %b, expected %b", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_dispatch(input dispatch_t got, input dispatch_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: dispatch_out got %h, expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_row(input int idx, input fust_row_t got, input fust_row_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: fust_rows[%0d] got %h, expected %h",
                     $time, idx, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_ready(input logic [`NUM_FU-1:0] got, input logic [`NUM_FU-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: issue_ready got %b, expected %b", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_outputs();
        logic [`NUM_FU-1:0] ready;
        if (uut.u_assert.failures != 0) begin
            $display("an assertion bound into dispatch_top failed before %0t", $time);
            stop_on_error();
        end
        check_freeze(freeze, model_freeze());
        check_dispatch(dispatch_out, model_disp);
        for (int r = 0; r < `NUM_FU; r++) begin
            check_row(r, fust_rows[r], model_rows[r]);
            ready[r] = model_rows[r].busy && model_rows[r].t1 == '0 && model_rows[r].t2 == '0;
        end
        check_ready(issue_ready, ready);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the stimulus loop ended", WATCHDOG_NS);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        instr           = '0;
        instr_valid     = 1'b0;
        wb              = '0;
        fu_done         = '0;
        branch_resolved = 1'b0;
        branch_miss     = 1'b0;
        model_disp      = '0;
        model_spec      = 1'b0;
        last_freeze     = 1'b0;
        foreach (model_s[i]) model_s[i] = '0;
        foreach (model_m[i]) model_m[i] = '0;
        foreach (model_rows[r]) model_rows[r] = '0;

        wait (nRST === 1'b1);
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge CLK);
            step_model();
            drive_inputs();
            @(negedge CLK);
            check_outputs();
        end

        $display("%0d instructions accepted, %0d stalled cycles", accepted, stalls);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic CLK,
    output logic nRST
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    // release on a rising edge so the first active cycle is the next one
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

`default_nettype wire
